/* src.f */
fetchPkg.sv
ctiPkg.sv
preDecode.sv
ctiQueue.sv
fetchStage2.sv
fetchStage2_props.sv
fetchChecker.sv
fetchTb.sv

/* Makefile */
# Verilator run of the fetch stage 2 testbench.

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module fetchTb -Mdir obj_dir -f src.f
	./obj_dir/VfetchTb | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* fetchTb.sv */
module fetchTb import fetchPkg::*; import ctiPkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS       = 6;
  localparam int MAX_TEST_CYCLES = 600;
  // Six tests at their longest, plus reset and the closing drain.
  localparam int CYCLE_LIMIT     = NUM_TESTS * MAX_TEST_CYCLES + 400;
  localparam int KIND_JUMP       = 1;
  localparam int KIND_BRANCH     = 4;

  logic                               clk;
  logic                               rstN;
  logic                               stall;
  logic                               recoverFlag;
  logic                               fs1Ready;
  logic [PC_W-1:0]                    pc;
  logic [FETCH_WIDTH-1:0][INST_W-1:0] bundle;
  slotPred_t [FETCH_WIDTH-1:0]        slotPred;
  logic [PC_W-1:0]                    addrRas;
  resolve_t                           resolve;
  logic                               commit;
  logic [FETCH_WIDTH-1:0]             instValid;
  fetchPacket_t [FETCH_WIDTH-1:0]     packets;
  redirect_t                          redirect;
  btbUpdate_t                         update;
  logic                               fs2Ready;
  logic                               ctiQueueFull;

  int seed        = 63;
  int testId      = 0;
  int cycleCount  = 0;
  int otherErrors = 0;
  int mismatches;
  int fillCount;

  fetchStage2 dut_i (
    .clk(clk), .rstN_i(rstN), .stall_i(stall), .recoverFlag_i(recoverFlag),
    .fs1Ready_i(fs1Ready), .pc_i(pc), .bundle_i(bundle), .slotPred_i(slotPred),
    .addrRas_i(addrRas), .resolve_i(resolve), .commit_i(commit), .instValid_o(instValid),
    .packets_o(packets), .redirect_o(redirect), .update_o(update), .fs2Ready_o(fs2Ready),
    .ctiQueueFull_o(ctiQueueFull)
  );

  fetchChecker monitor_i (
    .clk(clk), .rstN_i(rstN), .stall_i(stall), .recoverFlag_i(recoverFlag),
    .fs1Ready_i(fs1Ready), .pc_i(pc), .bundle_i(bundle), .slotPred_i(slotPred),
    .addrRas_i(addrRas), .resolve_i(resolve), .commit_i(commit), .instValid_i(instValid),
    .packets_i(packets), .redirect_i(redirect), .update_i(update), .fs2Ready_i(fs2Ready),
    .ctiQueueFull_i(ctiQueueFull), .testId_i(testId), .mismatchCount_o(mismatches)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CYCLE_LIMIT) begin
      $display("Timeout: the run passed %0d cycles without finishing", CYCLE_LIMIT);
      $display("Error counts: %0d mismatches, %0d other failures", mismatches, otherErrors + 1);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic bit chance(input int pct);
    return int'({$random(seed)} % 100) < pct;
  endfunction

  function automatic logic [INST_W-1:0] makeInst(input int kind, input logic [15:0] offset);
    logic [OPC_W-1:0] opc;
    case (kind)
      1: opc = OPC_JUMP;
      2: opc = OPC_CALL;
      3: opc = OPC_RET;
      4: opc = OPC_BRANCH;
      default: opc = 6'h21;  // Any opcode outside the control set.
    endcase
    return {opc, 10'h0, offset};
  endfunction

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  // A negative forceKind picks each slot's kind at random.
  task automatic driveBundle(input int ctrlPct, input int hitPct, input int takenPct,
                             input int forceKind);
    int kind;
    pc      = PC_W'($random(seed)) & 32'hFFFF_FFFC;
    addrRas = PC_W'($random(seed)) & 32'hFFFF_FFFC;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      if (forceKind >= 0) kind = forceKind;
      else if (chance(ctrlPct)) kind = 1 + int'({$random(seed)} % 4);
      else kind = 0;
      bundle[k]              = makeInst(kind, 16'($random(seed)));
      slotPred[k].btbHit     = chance(hitPct);
      slotPred[k].target     = PC_W'($random(seed)) & 32'hFFFF_FFFC;
      slotPred[k].prediction = chance(takenPct);
    end
  endtask

  initial begin
    rstN        = 1'b0;
    stall       = 1'b0;
    recoverFlag = 1'b0;
    fs1Ready    = 1'b0;
    commit      = 1'b0;
    resolve     = '0;
    driveBundle(0, 0, 0, 0);
    repeat (8) @(posedge clk);
    #1;
    rstN = 1'b1;

    testId   = 1;
    fs1Ready = 1'b1;
    repeat (20) begin
      driveBundle(0, 50, 50, -1);
      nextCycle();
    end

    testId = 2;
    repeat (80) begin
      driveBundle(60, 100, 50, -1);
      commit = chance(60);
      nextCycle();
    end

    testId = 3;
    repeat (80) begin
      driveBundle(60, 40, 50, -1);
      commit = chance(60);
      nextCycle();
    end

    // Start empty, then fill with not-taken branches that all allocate.
    testId      = 4;
    commit      = 1'b0;
    recoverFlag = 1'b1;
    nextCycle();
    recoverFlag = 1'b0;
    fillCount   = 0;
    while (!ctiQueueFull && fillCount < 8) begin
      driveBundle(100, 100, 0, KIND_BRANCH);
      nextCycle();
      fillCount++;
    end
    if (!ctiQueueFull) begin
      otherErrors++;
      $display("The queue never reported full after %0d bundles of branches", fillCount);
    end
    repeat (6) begin
      driveBundle(100, 0, 50, KIND_JUMP);
      nextCycle();
    end
    fs1Ready = 1'b0;
    commit   = 1'b1;
    repeat (4) nextCycle();
    commit   = 1'b0;
    fs1Ready = 1'b1;
    stall    = 1'b1;
    repeat (5) begin
      driveBundle(100, 0, 50, -1);
      nextCycle();
    end
    stall = 1'b0;
    repeat (4) begin
      driveBundle(80, 50, 50, -1);
      nextCycle();
    end

    testId = 5;
    repeat (120) begin
      driveBundle(50, 80, 50, -1);
      fs1Ready         = chance(80);
      stall            = chance(10);
      commit           = chance(50);
      resolve.verified = chance(50);
      resolve.tag      = CTIQ_LOG'($random(seed));
      resolve.target   = PC_W'($random(seed));
      resolve.taken    = chance(50);
      nextCycle();
    end

    testId   = 6;
    stall    = 1'b0;
    commit   = 1'b0;
    resolve  = '0;
    fs1Ready = 1'b1;
    repeat (3) begin
      driveBundle(100, 100, 0, KIND_BRANCH);
      nextCycle();
    end
    recoverFlag = 1'b1;
    nextCycle();
    recoverFlag = 1'b0;
    fs1Ready    = 1'b0;
    commit      = 1'b1;
    repeat (5) nextCycle();
    commit   = 1'b0;
    fs1Ready = 1'b1;
    repeat (3) begin
      driveBundle(100, 50, 50, -1);
      nextCycle();
    end
    fs1Ready = 1'b0;
    commit   = 1'b1;
    repeat (10) nextCycle();
    commit = 1'b0;
    repeat (3) nextCycle();

    $display("Error counts: %0d mismatches, %0d other failures", mismatches, otherErrors);
    if (mismatches + otherErrors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* fetchChecker.sv */
module fetchChecker import fetchPkg::*; import ctiPkg::*; (
  input  logic                               clk,
  input  logic                               rstN_i,
  input  logic                               stall_i,
  input  logic                               recoverFlag_i,
  input  logic                               fs1Ready_i,
  input  logic [PC_W-1:0]                    pc_i,
  input  logic [FETCH_WIDTH-1:0][INST_W-1:0] bundle_i,
  input  slotPred_t [FETCH_WIDTH-1:0]        slotPred_i,
  input  logic [PC_W-1:0]                    addrRas_i,
  input  resolve_t                           resolve_i,
  input  logic                               commit_i,
  input  logic [FETCH_WIDTH-1:0]             instValid_i,
  input  fetchPacket_t [FETCH_WIDTH-1:0]     packets_i,
  input  redirect_t                          redirect_i,
  input  btbUpdate_t                         update_i,
  input  logic                               fs2Ready_i,
  input  logic                               ctiQueueFull_i,
  input  int                                 testId_i,
  output int                                 mismatchCount_o
);
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [FETCH_WIDTH-1:0]         valid;
    logic [FETCH_WIDTH-1:0]         alloc;
    ctrlType_e [FETCH_WIDTH-1:0]    types;
    fetchPacket_t [FETCH_WIDTH-1:0] packets;
    redirect_t                      redirect;
  } expect_t;

  // Model of the control-transfer queue.
  logic [PC_W-1:0] mPc     [CTIQ_DEPTH];
  logic [PC_W-1:0] mTarget [CTIQ_DEPTH];
  ctrlType_e       mType   [CTIQ_DEPTH];
  logic            mTaken  [CTIQ_DEPTH];
  ctiqTag_t        mHead    = '0;
  ctiqTag_t        mTail    = '0;
  int              mCount   = 0;
  logic            updEnExp = 1'b0;
  btbUpdate_t      expUpd   = '0;
  int              errCount = 0;

  assign mismatchCount_o = errCount;

  function automatic string testName(input int id);
    case (id)
      1: return "straightLine";
      2: return "bundleCut";
      3: return "btbMiss";
      4: return "backPressure";
      5: return "resolveCommit";
      6: return "flush";
      default: return "reset";
    endcase
  endfunction

  // Expected valid vector, packets and redirect for one bundle.
  function automatic expect_t refStage(input logic [PC_W-1:0] pc,
                                       input logic [FETCH_WIDTH-1:0][INST_W-1:0] bundle,
                                       input slotPred_t [FETCH_WIDTH-1:0] pred,
                                       input logic [PC_W-1:0] ras,
                                       input ctiqTag_t tail);
    expect_t         e;
    logic            cut;
    logic            isCtrl;
    ctrlType_e       ty;
    logic [PC_W-1:0] slotPc;
    logic [PC_W-1:0] tgt;
    ctiqTag_t        tag;
    e   = '0;
    cut = 1'b0;
    tag = tail;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      slotPc = pc + PC_W'(k * INST_BYTES);
      tgt    = slotPc + 32'd4 + {{14{bundle[k][15]}}, bundle[k][15:0], 2'b00};
      isCtrl = 1'b1;
      case (bundle[k][31:26])
        OPC_JUMP:   ty = CT_JUMP;
        OPC_CALL:   ty = CT_CALL;
        OPC_BRANCH: ty = CT_BRANCH;
        OPC_RET: begin
          ty  = CT_RETURN;
          tgt = pred[k].target;
        end
        default: begin
          isCtrl = 1'b0;
          ty     = CT_JUMP;
          tgt    = pred[k].target;
        end
      endcase
      e.types[k] = ty;
      e.valid[k] = !cut;
      e.alloc[k] = !cut && isCtrl;
      if (!cut && isCtrl && (pred[k].prediction || ty != CT_BRANCH)) begin
        cut = 1'b1;
        if (!pred[k].btbHit) begin
          if (ty == CT_RETURN) tgt = ras;
          e.redirect = '{recover: 1'b1, isReturn: ty == CT_RETURN, isCall: ty == CT_CALL,
                         target: tgt, callPc: slotPc};
        end
      end
      e.packets[k] = '{instruction: bundle[k], pc: slotPc, target: tgt, ctiqTag: tag,
                       prediction: pred[k].prediction};
      if (e.alloc[k]) tag = tag + 1'b1;
    end
    return e;
  endfunction

  task automatic checkField(input string field, input logic [127:0] expVal,
                            input logic [127:0] actVal);
    if (expVal !== actVal) begin
      errCount++;
      $display("MISMATCH %s %s: expected %0h, actual %0h", testName(testId_i), field,
               expVal, actVal);
    end
  endtask

  // Inputs are stable here, and the model then steps across the coming rising edge.
  always @(negedge clk) begin : compareAndStep
    expect_t  e;
    logic     fullExp;
    logic     doAlloc;
    ctiqTag_t idx;
    e       = refStage(pc_i, bundle_i, slotPred_i, addrRas_i, mTail);
    fullExp = mCount > CTIQ_DEPTH - FETCH_WIDTH;
    e.redirect.recover = e.redirect.recover & ~stall_i & ~fullExp;
    if (rstN_i) begin
      checkField("instValid", 128'(e.valid), 128'(instValid_i));
      for (int k = 0; k < FETCH_WIDTH; k++) begin
        checkField($sformatf("packet%0d", k), 128'(e.packets[k]), 128'(packets_i[k]));
      end
      checkField("redirect", 128'(e.redirect), 128'(redirect_i));
      checkField("ctiQueueFull", 128'(fullExp), 128'(ctiQueueFull_i));
      checkField("fs2Ready", 128'(fs1Ready_i & ~fullExp), 128'(fs2Ready_i));
      if (updEnExp) checkField("update", 128'(expUpd), 128'(update_i));
      else checkField("update.en", 128'(1'b0), 128'(update_i.en));
    end
    if (!rstN_i) begin
      mHead    = '0;
      mTail    = '0;
      mCount   = 0;
      updEnExp = 1'b0;
    end else if (recoverFlag_i) begin
      updEnExp = 1'b0;
      mHead    = mTail;  // The tail pointer keeps its place.
      mCount   = 0;
    end else begin
      updEnExp = commit_i && (mCount != 0);
      if (updEnExp) begin
        expUpd = '{en: 1'b1, pc: mPc[mHead], target: mTarget[mHead],
                   ctrlType: mType[mHead], taken: mTaken[mHead]};
      end
      doAlloc = fs1Ready_i & ~stall_i & ~fullExp;
      for (int k = 0; k < FETCH_WIDTH; k++) begin
        if (doAlloc && e.alloc[k]) begin
          idx          = e.packets[k].ctiqTag;
          mPc[idx]     = e.packets[k].pc;
          mTarget[idx] = e.packets[k].target;
          mType[idx]   = e.types[k];
          mTaken[idx]  = (e.types[k] == CT_BRANCH) ? slotPred_i[k].prediction : 1'b1;
          mTail        = mTail + 1'b1;
          mCount++;
        end
      end
      if (updEnExp) begin
        mHead = mHead + 1'b1;
        mCount--;
      end
    end
    if (rstN_i && resolve_i.verified) begin
      mTarget[resolve_i.tag] = resolve_i.target;
      mTaken[resolve_i.tag]  = resolve_i.taken;
    end
  end

endmodule

/* fetchStage2_props.sv */
module fetchStage2Props import fetchPkg::*; import ctiPkg::*; (
  input logic                           clk,
  input logic                           rstN_i,
  input logic                           stall_i,
  input logic                           commit_i,
  input logic                           ctiQueueFull_i,
  input redirect_t                      redirect_i,
  input btbUpdate_t                     update_i,
  input fetchPacket_t [FETCH_WIDTH-1:0] packets_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Each update cycle follows a commit sampled at the edge before it.
  updateOnePulse: assert property (@(posedge clk) disable iff (!rstN_i)
    !commit_i |=> !update_i.en)
    else $error("Predictor update stayed high without a second commit.");

  noRecoverInStall: assert property (@(posedge clk) disable iff (!rstN_i)
    stall_i |-> !redirect_i.recover ##1 $stable(packets_i[0].ctiqTag))
    else $error("Redirect or allocation while the stage was stalled.");

  // Slot 0 always carries the tail, so a moving tag means an allocation.
  noAllocWhenFull: assert property (@(posedge clk) disable iff (!rstN_i)
    ctiQueueFull_i |=> $stable(packets_i[0].ctiqTag))
    else $error("Queue allocated while full.");

endmodule

bind fetchStage2 fetchStage2Props uProps (
  .clk(clk), .rstN_i(rstN_i), .stall_i(stall_i), .commit_i(commit_i),
  .ctiQueueFull_i(ctiQueueFull_o), .redirect_i(redirect_o), .update_i(update_o),
  .packets_i(packets_o)
);

/* fetchStage2.sv */
module fetchStage2 import fetchPkg::*; import ctiPkg::*; (
  input  logic                               clk,
  input  logic                               rstN_i,
  input  logic                               stall_i,
  input  logic                               recoverFlag_i,
  input  logic                               fs1Ready_i,
  input  logic [PC_W-1:0]                    pc_i,
  input  logic [FETCH_WIDTH-1:0][INST_W-1:0] bundle_i,
  input  slotPred_t [FETCH_WIDTH-1:0]        slotPred_i,
  input  logic [PC_W-1:0]                    addrRas_i,
  input  resolve_t                           resolve_i,
  input  logic                               commit_i,
  output logic [FETCH_WIDTH-1:0]             instValid_o,
  output fetchPacket_t [FETCH_WIDTH-1:0]     packets_o,
  output redirect_t                          redirect_o,
  output btbUpdate_t                         update_o,
  output logic                               fs2Ready_o,
  output logic                               ctiQueueFull_o
);

  logic [FETCH_WIDTH-1:0][PC_W-1:0] slotPc;
  logic [FETCH_WIDTH-1:0][PC_W-1:0] decTarget;
  logic [FETCH_WIDTH-1:0][PC_W-1:0] pktTarget;
  ctrlType_e [FETCH_WIDTH-1:0]      slotType;
  logic [FETCH_WIDTH-1:0]           isCtrl;
  logic [FETCH_WIDTH-1:0]           redirects;
  logic [FETCH_WIDTH-1:0]           slotPredBits;
  logic [FETCH_WIDTH-1:0]           allocVec;
  ctiqTag_t [FETCH_WIDTH-1:0]       slotTag;
  logic                             queueFull;
  redirect_t                        missRedirect;

  for (genvar k = 0; k < FETCH_WIDTH; k++) begin : gSlot
    assign slotPc[k]       = pc_i + PC_W'(k * INST_BYTES);
    assign slotPredBits[k] = slotPred_i[k].prediction;

    preDecode uPreDecode (
      .pc_i         (slotPc[k]),
      .instruction_i(bundle_i[k]),
      .pred_i       (slotPred_i[k]),
      .isCtrl_o     (isCtrl[k]),
      .ctrlType_o   (slotType[k]),
      .target_o     (decTarget[k])
    );

    // Taken prediction or an unconditional transfer sends fetch elsewhere.
    assign redirects[k] = isCtrl[k] &
                          (slotPred_i[k].prediction | (slotType[k] != CT_BRANCH));

    assign packets_o[k] = '{
      instruction: bundle_i[k],
      pc:          slotPc[k],
      target:      pktTarget[k],
      ctiqTag:     slotTag[k],
      prediction:  slotPred_i[k].prediction
    };
  end

  // Priority search for the first redirecting slot.
  always_comb begin : validateBtb
    logic found;
    found        = 1'b0;
    instValid_o  = '0;
    pktTarget    = decTarget;
    missRedirect = '0;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      instValid_o[k] = ~found;  // Slots after the cut are dropped.
      if (!found && redirects[k]) begin
        found = 1'b1;
        if (!slotPred_i[k].btbHit) begin
          missRedirect.recover  = 1'b1;
          missRedirect.isReturn = (slotType[k] == CT_RETURN);
          missRedirect.isCall   = (slotType[k] == CT_CALL);
          missRedirect.callPc   = slotPc[k];
          if (slotType[k] == CT_RETURN) begin
            missRedirect.target = addrRas_i;
            pktTarget[k]        = addrRas_i;
          end else begin
            missRedirect.target = decTarget[k];
          end
        end
      end
    end
  end

  // Not-taken branches ahead of the cut still need a queue entry.
  assign allocVec = instValid_o & isCtrl;

  // Recovery waits while the bundle cannot be accepted.
  assign redirect_o = '{
    recover:  missRedirect.recover & ~stall_i & ~queueFull,
    isReturn: missRedirect.isReturn,
    isCall:   missRedirect.isCall,
    target:   missRedirect.target,
    callPc:   missRedirect.callPc
  };

  ctiQueue uCtiQueue (
    .clk         (clk),
    .rstN_i      (rstN_i),
    .allocEn_i   (fs1Ready_i & ~stall_i),
    .allocVec_i  (allocVec),
    .slotPc_i    (slotPc),
    .slotType_i  (slotType),
    .slotTarget_i(pktTarget),
    .slotPred_i  (slotPredBits),
    .slotTag_o   (slotTag),
    .resolve_i   (resolve_i),
    .commit_i    (commit_i),
    .flush_i     (recoverFlag_i),
    .full_o      (queueFull),
    .update_o    (update_o)
  );

  assign ctiQueueFull_o = queueFull;
  assign fs2Ready_o     = fs1Ready_i & ~queueFull;

endmodule

/* ctiQueue.sv */
module ctiQueue import fetchPkg::*; import ctiPkg::*; (
  input  logic                               clk,
  input  logic                               rstN_i,
  input  logic                               allocEn_i,
  input  logic [FETCH_WIDTH-1:0]             allocVec_i,
  input  logic [FETCH_WIDTH-1:0][PC_W-1:0]   slotPc_i,
  input  ctrlType_e [FETCH_WIDTH-1:0]        slotType_i,
  input  logic [FETCH_WIDTH-1:0][PC_W-1:0]   slotTarget_i,
  input  logic [FETCH_WIDTH-1:0]             slotPred_i,
  output ctiqTag_t [FETCH_WIDTH-1:0]         slotTag_o,
  input  resolve_t                           resolve_i,
  input  logic                               commit_i,
  input  logic                               flush_i,
  output logic                               full_o,
  output btbUpdate_t                         update_o
);

  typedef struct packed {
    logic [PC_W-1:0] pc;
    logic [PC_W-1:0] target;
    ctrlType_e       ctrlType;
    logic            taken;
  } ctiqEntry_t;

  ctiqEntry_t entries [CTIQ_DEPTH];

  ctiqTag_t          headPtr;
  ctiqTag_t          tailPtr;
  ctiqTag_t          tailNext;
  logic [CTIQ_LOG:0] count;       // One extra bit so a full queue reads as CTIQ_DEPTH.
  logic [CTIQ_LOG:0] allocCount;
  logic              doAlloc;
  logic              doCommit;

  ctiqEntry_t        retired;
  logic              updateEn;

  // Fewer free entries than one bundle may need.
  assign full_o = count > (CTIQ_LOG+1)'(CTIQ_DEPTH - FETCH_WIDTH);

  assign doAlloc  = allocEn_i & ~full_o & ~flush_i;
  assign doCommit = commit_i & (count != '0) & ~flush_i;

  // Each control slot gets the tail plus the number of control slots before it.
  always_comb begin : tagAssign
    ctiqTag_t nextTag;
    nextTag    = tailPtr;
    allocCount = '0;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      slotTag_o[k] = nextTag;
      if (allocVec_i[k]) begin
        nextTag    = nextTag + 1'b1;
        allocCount = allocCount + 1'b1;
      end
    end
    tailNext = nextTag;
  end

  always_ff @(posedge clk) begin
    if (doAlloc) begin
      for (int k = 0; k < FETCH_WIDTH; k++) begin
        if (allocVec_i[k]) begin
          entries[slotTag_o[k]].pc       <= slotPc_i[k];
          entries[slotTag_o[k]].target   <= slotTarget_i[k];
          entries[slotTag_o[k]].ctrlType <= slotType_i[k];
          // Only a conditional branch can be predicted not taken.
          entries[slotTag_o[k]].taken    <= (slotType_i[k] == CT_BRANCH) ? slotPred_i[k] : 1'b1;
        end
      end
    end
    if (resolve_i.verified) begin
      entries[resolve_i.tag].target <= resolve_i.target;
      entries[resolve_i.tag].taken  <= resolve_i.taken;
    end
  end

  // A flush drops every entry but leaves the tail where it is.
  always_ff @(posedge clk) begin
    if (!rstN_i) begin
      headPtr <= '0;
      tailPtr <= '0;
      count   <= '0;
    end else if (flush_i) begin
      headPtr <= tailPtr;
      count   <= '0;
    end else begin
      if (doAlloc) begin
        tailPtr <= tailNext;
      end
      if (doCommit) begin
        headPtr <= headPtr + 1'b1;
      end
      count <= count + (doAlloc ? allocCount : '0) - (CTIQ_LOG+1)'(doCommit);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN_i) begin
      updateEn <= 1'b0;
    end else begin
      updateEn <= doCommit;
    end
  end

  always_ff @(posedge clk) begin
    if (doCommit) begin
      retired <= entries[headPtr];  // Holds any resolution from earlier cycles.
    end
  end

  assign update_o = '{
    en:       updateEn,
    pc:       retired.pc,
    target:   retired.target,
    ctrlType: retired.ctrlType,
    taken:    retired.taken
  };

endmodule

/* preDecode.sv */
module preDecode import fetchPkg::*; (
  input  logic [PC_W-1:0]   pc_i,
  input  logic [INST_W-1:0] instruction_i,
  input  slotPred_t         pred_i,
  output logic              isCtrl_o,
  output ctrlType_e         ctrlType_o,
  output logic [PC_W-1:0]   target_o
);

  logic [OPC_W-1:0] opcode;
  logic [PC_W-1:0]  offsetBytes;
  logic [PC_W-1:0]  relTarget;

  assign opcode = instruction_i[INST_W-1 -: OPC_W];

  // Sign extend the word offset and scale it to bytes.
  assign offsetBytes = {{(PC_W-OFF_W-2){instruction_i[OFF_W-1]}},
                        instruction_i[OFF_W-1:0], 2'b00};

  // Relative to the address of the following instruction.
  assign relTarget = pc_i + PC_W'(INST_BYTES) + offsetBytes;

  always_comb begin
    isCtrl_o   = 1'b1;
    ctrlType_o = CT_JUMP;
    target_o   = relTarget;
    case (opcode)
      OPC_JUMP: begin
        ctrlType_o = CT_JUMP;
      end
      OPC_CALL: begin
        ctrlType_o = CT_CALL;
      end
      OPC_BRANCH: begin
        ctrlType_o = CT_BRANCH;
      end
      OPC_RET: begin
        // The return address is unknown here. Trust the BTB until the miss check.
        ctrlType_o = CT_RETURN;
        target_o   = pred_i.target;
      end
      default: begin
        isCtrl_o   = 1'b0;
        ctrlType_o = CT_JUMP;        // Don't care for plain instructions.
        target_o   = pred_i.target;
      end
    endcase
  end

endmodule

/* ctiPkg.sv */
package ctiPkg;

  import fetchPkg::*;

  localparam int CTIQ_LOG   = TAG_W;
  localparam int CTIQ_DEPTH = 1 << CTIQ_LOG;

  typedef logic [CTIQ_LOG-1:0] ctiqTag_t;

  // Result written back by the execute stage.
  typedef struct packed {
    logic            verified;  // One-cycle strobe.
    ctiqTag_t        tag;
    logic [PC_W-1:0] target;
    logic            taken;
  } resolve_t;

  // Fetch redirect raised on a BTB miss.
  typedef struct packed {
    logic            recover;
    logic            isReturn;
    logic            isCall;
    logic [PC_W-1:0] target;
    logic [PC_W-1:0] callPc;
  } redirect_t;

  // One retired entry sent to the predictor.
  typedef struct packed {
    logic            en;
    logic [PC_W-1:0] pc;
    logic [PC_W-1:0] target;
    ctrlType_e       ctrlType;
    logic            taken;
  } btbUpdate_t;

endpackage

/* fetchPkg.sv */
package fetchPkg;

  localparam int FETCH_WIDTH = 4;
  localparam int PC_W        = 32;
  localparam int INST_W      = 32;
  localparam int INST_BYTES  = 4;

  // Width of the control-transfer queue tag. ctiPkg derives its depth from this.
  localparam int TAG_W = 4;

  // The opcode sits in the top bits of the instruction word.
  localparam int OPC_W = 6;
  // Jump, call and branch carry a signed word offset in the low bits.
  localparam int OFF_W = 16;

  localparam logic [OPC_W-1:0] OPC_JUMP   = 6'h02;
  localparam logic [OPC_W-1:0] OPC_CALL   = 6'h03;
  localparam logic [OPC_W-1:0] OPC_BRANCH = 6'h04;
  localparam logic [OPC_W-1:0] OPC_RET    = 6'h08;

  // Bit pattern 2'b11 marks the only conditional type.
  typedef enum logic [1:0] {
    CT_RETURN = 2'd0,
    CT_CALL   = 2'd1,
    CT_JUMP   = 2'd2,
    CT_BRANCH = 2'd3
  } ctrlType_e;

  // Per-slot result from the branch target buffer.
  typedef struct packed {
    logic            btbHit;
    logic [PC_W-1:0] target;
    logic            prediction;  // Predicted direction.
  } slotPred_t;

  // Packet handed to the decode stage for one slot.
  typedef struct packed {
    logic [INST_W-1:0] instruction;
    logic [PC_W-1:0]   pc;
    logic [PC_W-1:0]   target;
    logic [TAG_W-1:0]  ctiqTag;
    logic              prediction;
  } fetchPacket_t;

endpackage
